// ==== ppu_pkg.sv ====
// ppu shared definitions
// dot and line timing, cpu register map and the vector types of the background path
`default_nettype none

package ppu_pkg;

	// --------------------
	// vector types
	// --------------------

	// cpu register or vram data byte
	typedef logic [7:0] byte_t;
	// 8 KB vram byte address
	typedef logic [12:0] vram_addr_t;
	// dot inside a line, 0..455
	typedef logic [8:0] hcnt_t;
	// line inside a frame, 0..153
	typedef logic [7:0] line_t;
	// raw 2 bit tile colour before the palette
	typedef logic [1:0] color_t;
	// lcd shade after the palette
	typedef logic [1:0] shade_t;

	// stat mode field encoding
	typedef enum logic [1:0] {
		MODE_HBLANK = 2'd0,
		MODE_VBLANK = 2'd1,
		MODE_OAM    = 2'd2,
		MODE_DRAW   = 2'd3
	} ppu_mode_t;

	// --------------------
	// line and frame timing
	// --------------------
	localparam int LINE_DOTS     = 456;
	localparam int FRAME_LINES   = 154;
	localparam int VISIBLE_LINES = 144;
	// oam search length, drawing starts right after it
	localparam int OAM_LEN       = 80;
	localparam int SCREEN_W      = 160;
	// first dot of the lcd output window
	localparam int OUT_START     = 250;
	// scroll registers are sampled two dots before drawing
	localparam int SCROLL_LATCH  = 78;

	// --------------------
	// cpu register map
	// --------------------
	localparam byte_t ADDR_LCDC = 8'h40;
	localparam byte_t ADDR_STAT = 8'h41;
	localparam byte_t ADDR_SCY  = 8'h42;
	localparam byte_t ADDR_SCX  = 8'h43;
	localparam byte_t ADDR_LY   = 8'h44;
	localparam byte_t ADDR_LYC  = 8'h45;
	localparam byte_t ADDR_BGP  = 8'h47;

	// both tile maps live in the top 2 KB of vram
	localparam logic [1:0] MAP_BASE = 2'b11;

endpackage

`default_nettype wire

// ==== ppu_regs_if.sv ====
// ppu register bundle
// register file values seen by the line timer, fetcher and line buffer
`timescale 1ns/1ns
`default_nettype none

interface ppu_regs_if;
	import ppu_pkg::*;

	// decoded lcdc bits
	logic       lcd_on;
	logic       bg_map_sel;
	logic       tile_data_sel;
	logic       bg_ena;
	// stat enables, bit 3 is lyc, bit 0 is hblank
	logic [3:0] stat_ena;
	byte_t      scy;
	byte_t      scx;
	byte_t      lyc;
	byte_t      bgp;

	modport src (output lcd_on, bg_map_sel, tile_data_sel, bg_ena, stat_ena,
		scy, scx, lyc, bgp);
	modport snk (input lcd_on, bg_map_sel, tile_data_sel, bg_ena, stat_ena,
		scy, scx, lyc, bgp);

endinterface

`default_nettype wire

// ==== ppu_timing_if.sv ====
// ppu line position bundle
// dot and line counters plus per line scroll state from the line timer
`timescale 1ns/1ns
`default_nettype none

interface ppu_timing_if;
	import ppu_pkg::*;

	hcnt_t h_cnt;
	line_t v_cnt;
	// lines 144 and above
	logic  vblank;
	// background fetch window of the current line
	logic  draw;
	// fine scroll costs one more tile fetch
	logic  extra_tile;
	byte_t scy_r;
	byte_t scx_r;

	modport src (output h_cnt, v_cnt, vblank, draw, extra_tile, scy_r, scx_r);
	modport snk (input h_cnt, v_cnt, vblank, draw, extra_tile, scy_r, scx_r);

endinterface

`default_nettype wire

// ==== ppu_reg_file.sv ====
// ppu cpu register file
// holds lcdc, stat enables, scroll, lyc and bgp and builds the cpu read data
`timescale 1ns/1ns
`default_nettype none

module ppu_reg_file (
	input  wire                clk,
	input  wire                reset,
	input  wire                cpu_sel,
	input  wire                cpu_wr,
	input  ppu_pkg::byte_t     cpu_addr,
	input  ppu_pkg::byte_t     cpu_wdata,
	output ppu_pkg::byte_t     cpu_rdata,
	input  ppu_pkg::line_t     ly,
	input  ppu_pkg::ppu_mode_t mode,
	ppu_regs_if.src            regs
);
	import ppu_pkg::*;

	byte_t      lcdc;
	// stat bits 6..3, the rest of stat is status only
	logic [3:0] stat_ena;
	byte_t      scy;
	byte_t      scx;
	byte_t      lyc;
	byte_t      bgp;
	logic       lyc_match;

	assign lyc_match = (ly == lyc);

	// --------------------
	// cpu writes
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			// lcd starts off so boot code can fill vram
			lcdc     <= 8'h00;
			stat_ena <= 4'h0;
			scy      <= 8'h00;
			scx      <= 8'h00;
			lyc      <= 8'h00;
			bgp      <= 8'hfc;
		end else if (cpu_sel && cpu_wr) begin
			case (cpu_addr)
				ADDR_LCDC: lcdc <= cpu_wdata;
				ADDR_STAT: stat_ena <= cpu_wdata[6:3];
				ADDR_SCY:  scy <= cpu_wdata;
				ADDR_SCX:  scx <= cpu_wdata;
				ADDR_LYC:  lyc <= cpu_wdata;
				ADDR_BGP:  bgp <= cpu_wdata;
				// ly and unmapped addresses ignore writes
				default: ;
			endcase
		end
	end

	// --------------------
	// cpu reads
	// --------------------
	always_comb begin
		case (cpu_addr)
			ADDR_LCDC: cpu_rdata = lcdc;
			// bit 7 always reads as one
			ADDR_STAT: cpu_rdata = {1'b1, stat_ena, lyc_match, mode};
			ADDR_SCY:  cpu_rdata = scy;
			ADDR_SCX:  cpu_rdata = scx;
			ADDR_LY:   cpu_rdata = ly;
			ADDR_LYC:  cpu_rdata = lyc;
			ADDR_BGP:  cpu_rdata = bgp;
			default:   cpu_rdata = 8'hff;
		endcase
	end

	// decoded lcdc fields for the rest of the ppu
	assign regs.lcd_on        = lcdc[7];
	assign regs.tile_data_sel = lcdc[4];
	assign regs.bg_map_sel    = lcdc[3];
	assign regs.bg_ena        = lcdc[0];
	assign regs.stat_ena      = stat_ena;
	assign regs.scy           = scy;
	assign regs.scx           = scx;
	assign regs.lyc           = lyc;
	assign regs.bgp           = bgp;

endmodule

`default_nettype wire

// ==== ppu_line_timer.sv ====
// ppu line timer
// dot and line counters, per line scroll latch, stat mode and stat interrupt
`timescale 1ns/1ns
`default_nettype none

module ppu_line_timer (
	input  wire                 clk,
	input  wire                 reset,
	ppu_regs_if.snk             regs,
	ppu_timing_if.src           tim,
	output ppu_pkg::ppu_mode_t  mode,
	output logic                irq
);
	import ppu_pkg::*;

	// drawing without fine scroll covers one screen width
	localparam hcnt_t DRAW_END = hcnt_t'(OAM_LEN + SCREEN_W);

	hcnt_t     draw_end;
	ppu_mode_t mode_next;
	logic      irq_next;

	// --------------------
	// counters
	// --------------------
	always_ff @(posedge clk) begin
		if (reset || !regs.lcd_on) begin
			// held at line 0 dot 0 while the lcd is off
			tim.h_cnt <= '0;
			tim.v_cnt <= '0;
		end else if (tim.h_cnt == hcnt_t'(LINE_DOTS - 1)) begin
			tim.h_cnt <= '0;
			if (tim.v_cnt == line_t'(FRAME_LINES - 1))
				tim.v_cnt <= '0;
			else
				tim.v_cnt <= tim.v_cnt + 8'd1;
		end else begin
			tim.h_cnt <= tim.h_cnt + 9'd1;
		end
	end

	// scroll stays stable for the whole fetch of a line
	always_ff @(posedge clk) begin
		if (regs.lcd_on && tim.h_cnt == hcnt_t'(SCROLL_LATCH)) begin
			tim.scx_r <= regs.scx;
			tim.scy_r <= regs.scy;
		end
	end

	// an unaligned scx needs one more tile, so drawing runs 8 dots longer
	always_ff @(posedge clk) begin
		if (reset)
			tim.extra_tile <= 1'b0;
		else if (tim.h_cnt == hcnt_t'(OAM_LEN))
			tim.extra_tile <= (tim.scx_r[2:0] != 3'd0);
	end

	assign draw_end   = DRAW_END + {5'd0, tim.extra_tile, 3'd0};
	assign tim.vblank = (tim.v_cnt >= line_t'(VISIBLE_LINES));
	assign tim.draw   = regs.lcd_on && !tim.vblank &&
		(tim.h_cnt >= hcnt_t'(OAM_LEN)) && (tim.h_cnt < draw_end);

	// --------------------
	// mode
	// --------------------
	always_comb begin
		if (!regs.lcd_on)
			mode_next = MODE_HBLANK;
		else if (tim.vblank)
			mode_next = MODE_VBLANK;
		else if (tim.h_cnt < hcnt_t'(OAM_LEN))
			mode_next = MODE_OAM;
		else if (tim.draw)
			mode_next = MODE_DRAW;
		else
			mode_next = MODE_HBLANK;
	end

	// --------------------
	// stat interrupt
	// --------------------
	// stat_ena[3] ly=lyc, [2] oam start, [1] vblank start, [0] hblank start
	assign irq_next = regs.lcd_on && (
		(regs.stat_ena[3] && tim.h_cnt == 9'd1 && tim.v_cnt == regs.lyc) ||
		(regs.stat_ena[2] && tim.h_cnt == 9'd0) ||
		(regs.stat_ena[1] && tim.h_cnt == hcnt_t'(LINE_DOTS - 1) &&
			tim.v_cnt == line_t'(VISIBLE_LINES - 1)) ||
		(regs.stat_ena[0] && !tim.vblank && tim.h_cnt == draw_end));

	always_ff @(posedge clk) begin
		if (reset) begin
			mode <= MODE_HBLANK;
			irq  <= 1'b0;
		end else begin
			mode <= mode_next;
			irq  <= irq_next;
		end
	end

endmodule

`default_nettype wire

// ==== ppu_bg_fetcher.sv ====
// ppu background fetcher
// reads tile map and tile data from vram in two dot slots and shifts out
// one background pixel per dot and drops the fine scroll pixels at the line start
`timescale 1ns/1ns
`default_nettype none

module ppu_bg_fetcher #(
	parameter int SCREEN_W = ppu_pkg::SCREEN_W
) (
	input  wire                  clk,
	input  wire                  reset,
	ppu_regs_if.snk              regs,
	ppu_timing_if.snk            tim,
	output ppu_pkg::vram_addr_t  vram_addr,
	output logic                 vram_rd,
	input  ppu_pkg::byte_t       vram_data,
	output logic                 pix_valid,
	output ppu_pkg::color_t      pix_color
);
	import ppu_pkg::*;

	// slot order inside each 8 dot tile cycle
	localparam logic [1:0] SLOT_MAP  = 2'd0;
	localparam logic [1:0] SLOT_LO   = 2'd1;
	localparam logic [1:0] SLOT_HI   = 2'd2;
	localparam logic [1:0] SLOT_LOAD = 2'd3;

	logic [1:0] slot;
	// high on the second dot of a slot where vram data is valid
	logic       slot_last;
	byte_t      bg_line;
	logic [4:0] tile_cnt;
	logic [4:0] map_col;
	logic       tile_a12;
	byte_t      tile_idx;
	byte_t      data_lo;
	byte_t      data_hi;
	byte_t      shift_lo;
	byte_t      shift_hi;
	logic       start;
	logic       active;
	logic [3:0] skip;
	byte_t      pcnt;

	// drawing starts on a multiple of 8, so the dot counter gives the slot
	assign slot      = tim.h_cnt[2:1];
	assign slot_last = tim.h_cnt[0];
	assign bg_line   = tim.v_cnt + tim.scy_r;
	assign map_col   = tim.scx_r[7:3] + tile_cnt;

	// lcdc bit 4 clear selects signed indexing around 0x1000
	assign tile_a12 = !regs.tile_data_sel && !tile_idx[7];

	// --------------------
	// vram access
	// --------------------
	always_comb begin
		case (slot)
			SLOT_LO: vram_addr = {tile_a12, tile_idx, bg_line[2:0], 1'b0};
			SLOT_HI: vram_addr = {tile_a12, tile_idx, bg_line[2:0], 1'b1};
			default: vram_addr = {MAP_BASE, regs.bg_map_sel, bg_line[7:3], map_col};
		endcase
	end

	// load slot has no vram access
	assign vram_rd = tim.draw && (slot != SLOT_LOAD);

	always_ff @(posedge clk) begin
		if (tim.draw && slot_last) begin
			case (slot)
				SLOT_MAP: tile_idx <= vram_data;
				SLOT_LO:  data_lo <= vram_data;
				SLOT_HI:  data_hi <= vram_data;
				default: ;
			endcase
		end
	end

	// map column advances once per tile and restarts on every line
	always_ff @(posedge clk) begin
		if (reset || !tim.draw)
			tile_cnt <= 5'd0;
		else if (slot == SLOT_LOAD && slot_last)
			tile_cnt <= tile_cnt + 5'd1;
	end

	// --------------------
	// pixel shifter
	// --------------------
	// shifts msb first and keeps going past the fetch window to drain the last tile
	always_ff @(posedge clk) begin
		if (tim.draw && slot == SLOT_LOAD && slot_last) begin
			shift_lo <= data_lo;
			shift_hi <= data_hi;
		end else begin
			shift_lo <= {shift_lo[6:0], 1'b0};
			shift_hi <= {shift_hi[6:0], 1'b0};
		end
	end

	// first tile reaches the shifter 8 dots after drawing starts
	assign start = tim.draw && (tim.h_cnt == hcnt_t'(OAM_LEN));

	always_ff @(posedge clk) begin
		if (reset || !regs.lcd_on) begin
			active <= 1'b0;
			skip   <= 4'd0;
			pcnt   <= 8'd0;
		end else if (start) begin
			active <= 1'b1;
			// 7 dots of pipeline plus the fine scroll pixels
			skip   <= 4'd7 + {1'b0, tim.scx_r[2:0]};
			pcnt   <= 8'd0;
		end else if (active) begin
			if (skip != 4'd0) begin
				skip <= skip - 4'd1;
			end else begin
				pcnt <= pcnt + 8'd1;
				if (pcnt == byte_t'(SCREEN_W - 1))
					active <= 1'b0;
			end
		end
	end

	assign pix_valid = active && (skip == 4'd0);
	assign pix_color = {shift_hi[7], shift_lo[7]};

endmodule

`default_nettype wire

// ==== ppu_line_buffer.sv ====
// ppu line buffer
// stores one line of background colours and plays them out through bgp
// in a fixed lcd window
`timescale 1ns/1ns
`default_nettype none

module ppu_line_buffer #(
	parameter int SCREEN_W = ppu_pkg::SCREEN_W
) (
	input  wire               clk,
	input  wire               reset,
	ppu_regs_if.snk           regs,
	ppu_timing_if.snk         tim,
	input  wire               pix_valid,
	input  ppu_pkg::color_t   pix_color,
	output logic              lcd_clkena,
	output ppu_pkg::shade_t   lcd_data
);
	import ppu_pkg::*;

	color_t line_mem [SCREEN_W];
	byte_t  wptr;
	byte_t  rptr;
	logic   out_win;
	color_t rd_color;
	shade_t rd_shade;

	// --------------------
	// write side
	// --------------------
	always_ff @(posedge clk) begin
		if (pix_valid)
			line_mem[wptr] <= pix_color;
	end

	// --------------------
	// read side
	// --------------------
	// one dot early so the registered output lines up with dot OUT_START
	assign out_win = regs.lcd_on && !tim.vblank &&
		(tim.h_cnt >= hcnt_t'(OUT_START - 1)) &&
		(tim.h_cnt < hcnt_t'(OUT_START - 1 + SCREEN_W));

	assign rd_color = line_mem[rptr];

	// bgp holds four 2 bit shades, colour 0 in the low bits
	always_comb begin
		case (rd_color)
			2'd0:    rd_shade = regs.bgp[1:0];
			2'd1:    rd_shade = regs.bgp[3:2];
			2'd2:    rd_shade = regs.bgp[5:4];
			default: rd_shade = regs.bgp[7:6];
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset || !regs.lcd_on || tim.h_cnt == hcnt_t'(LINE_DOTS - 1)) begin
			wptr <= 8'd0;
			rptr <= 8'd0;
		end else begin
			if (pix_valid)
				wptr <= wptr + 8'd1;
			if (out_win)
				rptr <= rptr + 8'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			lcd_clkena <= 1'b0;
			lcd_data   <= 2'd0;
		end else begin
			lcd_clkena <= out_win;
			// background disabled shows shade 0
			lcd_data   <= regs.bg_ena ? rd_shade : 2'd0;
		end
	end

endmodule

`default_nettype wire

// ==== ppu_top.sv ====
// ppu background path top level
// register file, line timer, background fetcher and line buffer
`timescale 1ns/1ns
`default_nettype none

module ppu_top (
	input  wire                  clk,
	input  wire                  reset,
	// cpu register port
	input  wire                  cpu_sel,
	input  wire                  cpu_wr,
	input  ppu_pkg::byte_t       cpu_addr,
	input  ppu_pkg::byte_t       cpu_wdata,
	output ppu_pkg::byte_t       cpu_rdata,
	// lcd
	output logic                 lcd_on,
	output logic                 lcd_clkena,
	output ppu_pkg::shade_t      lcd_data,
	output logic                 irq,
	output ppu_pkg::ppu_mode_t   mode,
	// vram
	output logic                 vram_rd,
	output ppu_pkg::vram_addr_t  vram_addr,
	input  ppu_pkg::byte_t       vram_data
);
	import ppu_pkg::*;

	ppu_mode_t mode_w;
	logic      pix_valid;
	color_t    pix_color;

	ppu_regs_if   regs_if ();
	ppu_timing_if tim_if ();

	ppu_reg_file ppu_reg_file_i (
		.clk       (clk),
		.reset     (reset),
		.cpu_sel   (cpu_sel),
		.cpu_wr    (cpu_wr),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_rdata (cpu_rdata),
		.ly        (tim_if.v_cnt),
		.mode      (mode_w),
		.regs      (regs_if)
	);

	ppu_line_timer ppu_line_timer_i (
		.clk   (clk),
		.reset (reset),
		.regs  (regs_if),
		.tim   (tim_if),
		.mode  (mode_w),
		.irq   (irq)
	);

	ppu_bg_fetcher #(
		.SCREEN_W (SCREEN_W)
	) ppu_bg_fetcher_i (
		.clk       (clk),
		.reset     (reset),
		.regs      (regs_if),
		.tim       (tim_if),
		.vram_addr (vram_addr),
		.vram_rd   (vram_rd),
		.vram_data (vram_data),
		.pix_valid (pix_valid),
		.pix_color (pix_color)
	);

	ppu_line_buffer #(
		.SCREEN_W (SCREEN_W)
	) ppu_line_buffer_i (
		.clk        (clk),
		.reset      (reset),
		.regs       (regs_if),
		.tim        (tim_if),
		.pix_valid  (pix_valid),
		.pix_color  (pix_color),
		.lcd_clkena (lcd_clkena),
		.lcd_data   (lcd_data)
	);

	assign lcd_on = regs_if.lcd_on;
	assign mode   = mode_w;

endmodule

`default_nettype wire

// ==== ppu_tb_ref.svh ====
// ppu testbench reference model
// expected background shade of a screen pixel and expected cpu read data,
// worked out from the vram array and the testbench copies of the registers
`ifndef PPU_TB_REF_SVH
`define PPU_TB_REF_SVH

// shade of screen pixel (x, y) as the lcd should show it
function automatic shade_t expected_shade(input int x, input int y);
	byte_t      bx;
	byte_t      by;
	vram_addr_t map_addr;
	byte_t      tile_idx;
	int         idx_signed;
	int         row_addr;
	byte_t      lo;
	byte_t      hi;
	color_t     col;
	// background off blanks the whole line
	if (!lcdc_sh[0])
		return 2'd0;
	// scrolled background position, wraps at 256
	bx = byte_t'(x + scx_sh);
	by = byte_t'(y + scy_sh);
	// 32 by 32 tile map, lcdc bit 3 picks the map
	map_addr = {MAP_BASE, lcdc_sh[3], by[7:3], bx[7:3]};
	tile_idx = vram_mem[map_addr];
	// lcdc bit 4 set is unsigned from 0x0000, clear is signed around 0x1000
	if (lcdc_sh[4]) begin
		row_addr = int'(tile_idx) * 16;
	end else begin
		idx_signed = int'(tile_idx);
		if (tile_idx[7])
			idx_signed = idx_signed - 256;
		row_addr = 4096 + idx_signed * 16;
	end
	// two bytes per tile row
	row_addr = row_addr + 2 * int'(by % 8);
	lo = vram_mem[row_addr];
	hi = vram_mem[row_addr + 1];
	// leftmost pixel is bit 7
	col = {hi[7 - int'(bx % 8)], lo[7 - int'(bx % 8)]};
	return bgp_sh[2 * col +: 2];
endfunction

// value a cpu read of addr should return
function automatic byte_t expected_read(input byte_t addr, input line_t ly,
		input ppu_mode_t md);
	case (addr)
		ADDR_LCDC: return lcdc_sh;
		ADDR_STAT: return {1'b1, stat_sh[6:3], ly == lyc_sh, md};
		ADDR_SCY:  return scy_sh;
		ADDR_SCX:  return scx_sh;
		ADDR_LY:   return ly;
		ADDR_LYC:  return lyc_sh;
		ADDR_BGP:  return bgp_sh;
		// dropped registers and holes read as all ones
		default:   return 8'hff;
	endcase
endfunction

`endif

// ==== ppu_tb.sv ====
// ppu background path testbench
// drives the cpu port, models vram and checks every lcd pixel, the line
// and frame timing, the stat interrupt and the lcd off state
`timescale 1ns/1ns
`default_nettype none

module ppu_tb;
	import ppu_pkg::*;

	localparam int FRAME_CYCLES = LINE_DOTS * FRAME_LINES;
	// reset, register checks, four frames with the lcd on, then the lcd off phase
	localparam int CYCLE_LIMIT  = 16 + 4 * FRAME_CYCLES + 40 * LINE_DOTS;

	logic       clk;
	logic       reset;
	logic       cpu_sel;
	logic       cpu_wr;
	byte_t      cpu_addr;
	byte_t      cpu_wdata;
	byte_t      cpu_rdata;
	logic       lcd_on;
	logic       lcd_clkena;
	shade_t     lcd_data;
	logic       irq;
	ppu_mode_t  mode;
	logic       vram_rd;
	vram_addr_t vram_addr;
	byte_t      vram_data;

	// 8 KB vram model
	byte_t vram_mem [0:8191];
	int    seed = 32'hfe72_2e51;
	// vram address and read strobe as seen one clock earlier
	vram_addr_t vram_addr_q;
	logic       vram_rd_q;

	// testbench copies of the cpu registers
	byte_t lcdc_sh = 8'h00;
	byte_t stat_sh = 8'h00;
	byte_t scy_sh  = 8'h00;
	byte_t scx_sh  = 8'h00;
	byte_t lyc_sh  = 8'h00;
	byte_t bgp_sh  = 8'hfc;

	string test_name = "reset";
	int    error_count = 0;
	int    irq_count = 0;
	int    cycle_count = 0;
	int    pix_x = 0;
	int    pix_y = 0;
	logic  clkena_q = 1'b0;
	ppu_mode_t mode_q = MODE_HBLANK;

	`include "ppu_tb_ref.svh"

	ppu_top ppu_top_i (
		.clk        (clk),
		.reset      (reset),
		.cpu_sel    (cpu_sel),
		.cpu_wr     (cpu_wr),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.cpu_rdata  (cpu_rdata),
		.lcd_on     (lcd_on),
		.lcd_clkena (lcd_clkena),
		.lcd_data   (lcd_data),
		.irq        (irq),
		.mode       (mode),
		.vram_rd    (vram_rd),
		.vram_addr  (vram_addr),
		.vram_data  (vram_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------
	// helpers
	// --------------------
	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("FAIL %s %s: expected %0h, actual %0h",
				test_name, what, expected, actual);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// one cycle write strobe that also updates the register copies
	task automatic write_reg(input byte_t addr, input byte_t data);
		@(negedge clk);
		cpu_sel   = 1'b1;
		cpu_wr    = 1'b1;
		cpu_addr  = addr;
		cpu_wdata = data;
		case (addr)
			ADDR_LCDC: lcdc_sh = data;
			ADDR_STAT: stat_sh = data;
			ADDR_SCY:  scy_sh = data;
			ADDR_SCX:  scx_sh = data;
			ADDR_LYC:  lyc_sh = data;
			ADDR_BGP:  bgp_sh = data;
			default: ;
		endcase
		@(negedge clk);
		cpu_sel = 1'b0;
		cpu_wr  = 1'b0;
	endtask

	// read data is combinational and sampled just after the falling edge
	task automatic read_reg(input byte_t addr, output byte_t data);
		@(negedge clk);
		cpu_sel  = 1'b0;
		cpu_wr   = 1'b0;
		cpu_addr = addr;
		#1;
		data = cpu_rdata;
	endtask

	// walks the register page with the lcd off, where ly and mode are 0
	task automatic check_reg_page();
		byte_t rd;
		for (int a = 'h3f; a <= 'h4c; a++) begin
			read_reg(byte_t'(a), rd);
			check_value("register read", expected_read(byte_t'(a), 8'd0, MODE_HBLANK), rd);
		end
	endtask

	task automatic wait_mode(input ppu_mode_t m);
		@(negedge clk);
		while (mode != m)
			@(negedge clk);
	endtask

	// returns on dot 1 of line 0 when the registered mode leaves vblank
	task automatic wait_frame_start();
		wait_mode(MODE_VBLANK);
		while (mode == MODE_VBLANK)
			@(negedge clk);
	endtask

	// --------------------
	// vram and monitors
	// --------------------
	// data follows the address by one clock and reads as unknown without vram_rd
	always @(negedge clk) begin
		vram_addr_q <= vram_addr;
		vram_rd_q   <= vram_rd;
		vram_data   <= vram_rd_q ? vram_mem[vram_addr_q] : 8'hxx;
	end

	always @(negedge clk)
		if (irq)
			irq_count <= irq_count + 1;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test failed");
			$fatal(1);
		end
	end

	// pixel compare with 160 pixels per visible line and 144 lines per frame
	always @(negedge clk) begin
		if (reset || !lcd_on) begin
			pix_x = 0;
			pix_y = 0;
		end else begin
			if (lcd_clkena) begin
				check_value("pixel", expected_shade(pix_x, pix_y), lcd_data);
				pix_x++;
			end else if (clkena_q) begin
				check_value("pixels per line", SCREEN_W, pix_x);
				pix_x = 0;
				pix_y++;
			end
			if (mode == MODE_VBLANK && mode_q != MODE_VBLANK) begin
				check_value("lines per frame", VISIBLE_LINES, pix_y);
				pix_y = 0;
			end
			if (mode == MODE_VBLANK) begin
				check_value("output in vblank", 0, lcd_clkena);
				check_value("vram read in vblank", 0, vram_rd);
			end
		end
		clkena_q = lcd_clkena;
		mode_q   = mode;
	end

	// --------------------
	// stimulus
	// --------------------
	initial begin
		byte_t rd;
		byte_t scx_val;
		byte_t scy_val;
		int    irq_base;
		reset     = 1'b1;
		cpu_sel   = 1'b0;
		cpu_wr    = 1'b0;
		cpu_addr  = 8'h00;
		cpu_wdata = 8'h00;
		vram_data = 8'h00;
		for (int a = 0; a < 8192; a++)
			vram_mem[a] = byte_t'($random(seed));
		repeat (16) @(negedge clk);
		reset = 1'b0;

		@(negedge clk);
		check_value("irq", 0, irq);
		check_value("lcd_clkena", 0, lcd_clkena);
		check_value("mode", MODE_HBLANK, mode);
		check_value("lcd_on", 0, lcd_on);
		check_value("vram_rd", 0, vram_rd);
		check_reg_page();

		// register write and readback with the lcd kept off
		test_name = "registers";
		write_reg(ADDR_LCDC, 8'h11);
		write_reg(ADDR_SCX, 8'h5a);
		write_reg(ADDR_SCY, 8'ha5);
		write_reg(ADDR_LYC, 8'h3c);
		write_reg(ADDR_BGP, 8'h93);
		write_reg(ADDR_LY, 8'h77);
		check_reg_page();

		// first frame without scroll and with unsigned tiles from map 0
		test_name = "frame unscrolled";
		write_reg(ADDR_SCX, 8'h00);
		write_reg(ADDR_SCY, 8'h00);
		write_reg(ADDR_BGP, 8'h6c);
		write_reg(ADDR_LCDC, 8'h91);
		wait_mode(MODE_OAM);
		wait_mode(MODE_DRAW);
		wait_mode(MODE_HBLANK);
		wait_mode(MODE_VBLANK);
		read_reg(ADDR_LY, rd);
		check_value("ly in vblank", 1, rd >= VISIBLE_LINES);

		// second frame with random scroll, map 1 and signed tiles
		test_name = "frame scrolled";
		scx_val = byte_t'($random(seed));
		scy_val = byte_t'($random(seed));
		// keep a fine scroll so the extra tile is fetched
		if (scx_val[2:0] == 3'd0)
			scx_val[2:0] = 3'd3;
		write_reg(ADDR_SCX, scx_val);
		write_reg(ADDR_SCY, scy_val);
		write_reg(ADDR_LCDC, 8'h89);
		// vblank start enable only
		write_reg(ADDR_STAT, 8'h10);
		wait_frame_start();
		irq_base = irq_count;
		wait_frame_start();
		test_name = "vblank irq";
		check_value("irq per frame", 1, irq_count - irq_base);

		// third frame with only the ly=lyc enable
		test_name = "lyc irq";
		write_reg(ADDR_LYC, 8'd100);
		write_reg(ADDR_STAT, 8'h40);
		irq_base = irq_count;
		rd = 8'h00;
		while (rd != 8'd100)
			read_reg(ADDR_LY, rd);
		read_reg(ADDR_STAT, rd);
		// line 100 has just started, so the registered mode is still oam search
		check_value("stat at lyc", expected_read(ADDR_STAT, 8'd100, MODE_OAM), rd);
		wait_frame_start();
		check_value("irq per frame", 1, irq_count - irq_base);

		// fourth frame with the background disabled
		test_name = "bg off";
		write_reg(ADDR_LCDC, 8'h88);
		wait_mode(MODE_VBLANK);

		test_name = "lcd off";
		write_reg(ADDR_LCDC, 8'h08);
		@(negedge clk);
		for (int i = 0; i < 2 * LINE_DOTS; i++) begin
			@(negedge clk);
			check_value("lcd_on", 0, lcd_on);
			check_value("mode", MODE_HBLANK, mode);
			check_value("lcd_clkena", 0, lcd_clkena);
			check_value("vram_rd", 0, vram_rd);
		end
		read_reg(ADDR_LY, rd);
		check_value("ly", 0, rd);

		if (error_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
ppu_pkg.sv
ppu_regs_if.sv
ppu_timing_if.sv
ppu_reg_file.sv
ppu_line_timer.sv
ppu_bg_fetcher.sv
ppu_line_buffer.sv
ppu_top.sv
ppu_tb.sv
